//--- build.f
+incdir+include
hdl/mmu_pkg.sv
hdl/tlb_lookup.sv
hdl/tlb.sv
hdl/cp0_tlb_regs.sv
hdl/addr_translate.sv
hdl/mmu_top.sv
tests/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module mmu_tb -o mmu_sim

out=$(./obj_dir/mmu_sim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASS"

//--- include/mmu_model.svh
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// Reference copy of the TLB and its CP0 registers
mmu_pkg::tlb_entry_t           model_entries [mmu_pkg::TLB_ENTRIES];
mmu_pkg::tlb_key_t             model_hi;
mmu_pkg::tlb_page_t            model_lo0;
mmu_pkg::tlb_page_t            model_lo1;
logic                          model_g0;
logic                          model_g1;
logic                          model_probe_fail;
logic [mmu_pkg::TLB_IDX_W-1:0] model_index;
logic [mmu_pkg::TLB_IDX_W-1:0] model_random;

function automatic void reset_model_state();
    foreach (model_entries[i]) begin
        model_entries[i] = '0;
    end
    model_hi         = '0;
    model_lo0        = '0;
    model_lo1        = '0;
    model_g0         = 1'b0;
    model_g1         = 1'b0;
    model_probe_fail = 1'b0;
    model_index      = '0;
    model_random     = '1;
endfunction

function automatic logic [31:0] entrylo_image(mmu_pkg::tlb_page_t page, logic g);
    logic [31:0] r;
    r = '0;
    r[mmu_pkg::LO_PFN_LSB +: mmu_pkg::PFN_W] = page.pfn;
    r[mmu_pkg::LO_C_LSB +: 3]                = page.c;
    r[mmu_pkg::LO_D_BIT]                     = page.d;
    r[mmu_pkg::LO_V_BIT]                     = page.v;
    r[mmu_pkg::LO_G_BIT]                     = g;
    return r;
endfunction

function automatic mmu_pkg::tlb_page_t page_from_entrylo(logic [31:0] r);
    mmu_pkg::tlb_page_t page;
    page.pfn = r[mmu_pkg::LO_PFN_LSB +: mmu_pkg::PFN_W];
    page.c   = r[mmu_pkg::LO_C_LSB +: 3];
    page.d   = r[mmu_pkg::LO_D_BIT];
    page.v   = r[mmu_pkg::LO_V_BIT];
    return page;
endfunction

function automatic mmu_pkg::tlb_hit_t find_match(mmu_pkg::tlb_key_t key);
    mmu_pkg::tlb_hit_t hit;
    int                hits;
    hit  = '0;
    hits = 0;
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
        if (model_entries[i].vpn2 == key.vpn2 &&
            (model_entries[i].asid == key.asid || model_entries[i].g)) begin
            hits++;
            hit.index = i[mmu_pkg::TLB_IDX_W-1:0];
        end
    end
    hit.found = (hits != 0);
    if (hits != 1) begin
        hit.index = '0;
    end
    hit.lo0 = model_entries[hit.index].lo0;
    hit.lo1 = model_entries[hit.index].lo1;
    return hit;
endfunction

function automatic logic [31:0] read_cp0_reg(mmu_pkg::cp0_reg_e sel);
    logic [31:0] r;
    r = '0;
    case (sel)
        mmu_pkg::REG_INDEX: begin
            r[mmu_pkg::IDX_P_BIT]     = model_probe_fail;
            r[mmu_pkg::TLB_IDX_W-1:0] = model_index;
        end
        mmu_pkg::REG_RANDOM: r[mmu_pkg::TLB_IDX_W-1:0] = model_random;
        mmu_pkg::REG_ENTRYHI: begin
            r[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W] = model_hi.vpn2;
            r[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W] = model_hi.asid;
        end
        mmu_pkg::REG_ENTRYLO0: r = entrylo_image(model_lo0, model_g0);
        mmu_pkg::REG_ENTRYLO1: r = entrylo_image(model_lo1, model_g1);
        default: r = '0;
    endcase
    return r;
endfunction

// One operation as applied at the rising edge
function automatic void apply_cp0_op(mmu_pkg::cp0_op_e op, mmu_pkg::cp0_reg_e sel,
                                     logic [31:0] wdata);
    mmu_pkg::tlb_entry_t e;
    mmu_pkg::tlb_hit_t   hit;
    e   = model_entries[model_index];
    hit = find_match(model_hi);
    case (op)
        mmu_pkg::MTC0: begin
            case (sel)
                mmu_pkg::REG_INDEX: model_index = wdata[mmu_pkg::TLB_IDX_W-1:0];
                mmu_pkg::REG_ENTRYHI: begin
                    model_hi.vpn2 = wdata[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W];
                    model_hi.asid = wdata[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W];
                end
                mmu_pkg::REG_ENTRYLO0: begin
                    model_lo0 = page_from_entrylo(wdata);
                    model_g0  = wdata[mmu_pkg::LO_G_BIT];
                end
                mmu_pkg::REG_ENTRYLO1: begin
                    model_lo1 = page_from_entrylo(wdata);
                    model_g1  = wdata[mmu_pkg::LO_G_BIT];
                end
                default: begin
                end
            endcase
        end
        mmu_pkg::TLBP: begin
            model_probe_fail = !hit.found;
            model_index      = hit.index;
        end
        mmu_pkg::TLBR: begin
            model_hi.vpn2 = e.vpn2;
            model_hi.asid = e.asid;
            model_lo0     = e.lo0;
            model_lo1     = e.lo1;
            model_g0      = e.g;
            model_g1      = e.g;
        end
        mmu_pkg::TLBWI, mmu_pkg::TLBWR: begin
            e.vpn2 = model_hi.vpn2;
            e.asid = model_hi.asid;
            e.g    = model_g0 & model_g1;
            e.lo0  = model_lo0;
            e.lo1  = model_lo1;
            model_entries[(op == mmu_pkg::TLBWR) ? model_random : model_index] = e;
        end
        default: begin
        end
    endcase
    model_random = model_random - 1'b1;
endfunction

function automatic void predict_translation(input logic [31:0] vaddr, input logic store,
                                            output logic [31:0] paddr,
                                            output mmu_pkg::tlb_fault_e fault);
    mmu_pkg::tlb_key_t  key;
    mmu_pkg::tlb_hit_t  hit;
    mmu_pkg::tlb_page_t page;
    key.vpn2 = vaddr[31 -: mmu_pkg::VPN2_W];
    key.asid = model_hi.asid;
    hit      = find_match(key);
    page     = vaddr[12] ? hit.lo1 : hit.lo0;
    paddr    = {page.pfn, vaddr[11:0]};
    fault    = mmu_pkg::FAULT_NONE;
    if (vaddr[31:30] == 2'b10) begin
        paddr = {3'b000, vaddr[28:0]};
    end else if (!hit.found) begin
        fault = mmu_pkg::FAULT_REFILL;
    end else if (!page.v) begin
        fault = mmu_pkg::FAULT_INVALID;
    end else if (store && !page.d) begin
        fault = mmu_pkg::FAULT_MODIFIED;
    end
endfunction

`endif

//--- tests/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;
    logic                clk;
    logic                reset;
    mmu_pkg::cp0_op_e    cp0_op;
    mmu_pkg::cp0_reg_e   cp0_reg;
    logic [31:0]         cp0_wdata;
    logic [31:0]         cp0_rdata;
    logic [31:0]         inst_vaddr;
    logic [31:0]         inst_paddr;
    mmu_pkg::tlb_fault_e inst_fault;
    logic [31:0]         data_vaddr;
    logic                data_store;
    logic [31:0]         data_paddr;
    mmu_pkg::tlb_fault_e data_fault;

    `include "mmu_model.svh"

    mmu_top mmu_top_inst (
        .clk        (clk),
        .reset      (reset),
        .cp0_op     (cp0_op),
        .cp0_reg    (cp0_reg),
        .cp0_wdata  (cp0_wdata),
        .cp0_rdata  (cp0_rdata),
        .inst_vaddr (inst_vaddr),
        .inst_paddr (inst_paddr),
        .inst_fault (inst_fault),
        .data_vaddr (data_vaddr),
        .data_store (data_store),
        .data_paddr (data_paddr),
        .data_fault (data_fault)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Overall limit on the run
    initial begin
        #(8 * 5000);
        $display("Run did not finish within 5000 clock cycles");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // Small pools so that entries collide and hit often
    function automatic logic [mmu_pkg::VPN2_W-1:0] vpn2_from_pool();
        logic [mmu_pkg::VPN2_W-1:0] v;
        case ($urandom_range(3, 0))
            0:       v = 19'h00000;
            1:       v = 19'h00001;
            2:       v = 19'h0a5a5;
            default: v = 19'h7f001;  // kseg2 is still mapped
        endcase
        return v;
    endfunction

    function automatic logic [mmu_pkg::ASID_W-1:0] asid_from_pool();
        logic [mmu_pkg::ASID_W-1:0] a;
        case ($urandom_range(2, 0))
            0:       a = 8'h00;
            1:       a = 8'h01;
            default: a = 8'h5c;
        endcase
        return a;
    endfunction

    function automatic logic [31:0] make_vaddr();
        logic [31:0] a;
        a = $urandom;  // Fully random hits kseg0/kseg1 about a quarter of the time
        if ($urandom_range(4, 0) != 0) begin
            a[31:13] = vpn2_from_pool();
        end
        return a;
    endfunction

    task automatic apply_reset();
        int cycles;
        reset = 1'b1;
        @(posedge clk);
        cycles = 1;
        #7;
        // Random must load 15 during reset
        while (cp0_rdata !== 32'd15) begin
            if (cycles == 16) begin
                $display("Random did not reach its reset value while reset was held");
                $display("TEST FAIL");
                $fatal(1, "reset timeout");
            end
            @(posedge clk);
            cycles++;
            #7;
        end
        while (cycles < 16) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        reset = 1'b0;
    endtask

    task automatic drive_random_op();
        int pick;
        pick      = $urandom_range(99, 0);
        cp0_reg   = mmu_pkg::cp0_reg_e'($urandom_range(4, 0));
        cp0_wdata = $urandom;  // Junk in unused bits
        if (pick < 10) begin
            cp0_op = mmu_pkg::NOP;
        end else if (pick < 55) begin
            cp0_op = mmu_pkg::MTC0;
            if (cp0_reg == mmu_pkg::REG_ENTRYHI) begin
                cp0_wdata[31:13] = vpn2_from_pool();
                cp0_wdata[7:0]   = asid_from_pool();
            end
        end else if (pick < 65) begin
            cp0_op = mmu_pkg::TLBP;
        end else if (pick < 75) begin
            cp0_op = mmu_pkg::TLBR;
        end else if (pick < 90) begin
            cp0_op = mmu_pkg::TLBWI;
        end else begin
            cp0_op  = mmu_pkg::TLBWR;
            cp0_reg = mmu_pkg::REG_RANDOM;  // Shows the write index
        end
        inst_vaddr = make_vaddr();
        data_vaddr = make_vaddr();
        data_store = $urandom_range(1, 0) != 0;
    endtask

    task automatic check_outputs();
        logic [31:0]         exp_paddr;
        mmu_pkg::tlb_fault_e exp_fault;
        compare("cp0_rdata", read_cp0_reg(cp0_reg), cp0_rdata);
        predict_translation(inst_vaddr, 1'b0, exp_paddr, exp_fault);
        compare("inst_paddr", exp_paddr, inst_paddr);
        compare("inst_fault", exp_fault, inst_fault);
        // Data port belongs to the probe in a TLBP cycle
        if (cp0_op != mmu_pkg::TLBP) begin
            predict_translation(data_vaddr, data_store, exp_paddr, exp_fault);
            compare("data_paddr", exp_paddr, data_paddr);
            compare("data_fault", exp_fault, data_fault);
        end
    endtask

    initial begin
        void'($urandom(32'hf5c7_bd40));
        reset      = 1'b1;
        cp0_op     = mmu_pkg::NOP;
        cp0_reg    = mmu_pkg::REG_RANDOM;
        cp0_wdata  = '0;
        inst_vaddr = '0;
        data_vaddr = '0;
        data_store = 1'b0;
        reset_model_state();
        apply_reset();

        // All entries are zero straight out of reset
        inst_vaddr        = $urandom;
        inst_vaddr[31:13] = '0;
        data_vaddr        = $urandom;
        data_vaddr[31:13] = 19'h0a5a5;
        data_store        = $urandom_range(1, 0) != 0;
        #6;
        compare("cp0_rdata", 32'd15, cp0_rdata);
        compare("inst_fault", mmu_pkg::FAULT_INVALID, inst_fault);
        compare("data_fault", mmu_pkg::FAULT_REFILL, data_fault);
        apply_cp0_op(cp0_op, cp0_reg, cp0_wdata);

        for (int n = 0; n < 2000; n++) begin
            @(posedge clk);
            #1;
            drive_random_op();
            #6;
            check_outputs();
            apply_cp0_op(cp0_op, cp0_reg, cp0_wdata);  // Same update as the coming edge
        end

        $display("TEST PASS");
        $finish;
    end
endmodule

`default_nettype wire

//--- hdl/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::cp0_op_e    cp0_op,
    input  mmu_pkg::cp0_reg_e   cp0_reg,
    input  logic [31:0]         cp0_wdata,
    output logic [31:0]         cp0_rdata,
    input  logic [31:0]         inst_vaddr,
    output logic [31:0]         inst_paddr,
    output mmu_pkg::tlb_fault_e inst_fault,
    input  logic [31:0]         data_vaddr,
    input  logic                data_store,
    output logic [31:0]         data_paddr,
    output mmu_pkg::tlb_fault_e data_fault
);
    mmu_pkg::tlb_write_t           wr;
    logic [mmu_pkg::TLB_IDX_W-1:0] read_index;
    mmu_pkg::tlb_entry_t           read_entry;
    logic                          probe;
    mmu_pkg::tlb_key_t             probe_key;
    mmu_pkg::tlb_key_t             inst_key;
    mmu_pkg::tlb_key_t             data_key;
    mmu_pkg::tlb_hit_t             inst_hit;
    mmu_pkg::tlb_hit_t             data_hit;
    logic [mmu_pkg::ASID_W-1:0]    asid;

    cp0_tlb_regs cp0_tlb_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .op         (cp0_op),
        .sel        (cp0_reg),
        .wdata      (cp0_wdata),
        .rdata      (cp0_rdata),
        .wr         (wr),
        .read_index (read_index),
        .read_entry (read_entry),
        .probe      (probe),
        .probe_key  (probe_key),
        .probe_hit  (data_hit),
        .asid       (asid)
    );

    tlb tlb_inst (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .read_index (read_index),
        .read_entry (read_entry),
        .inst_key   (inst_key),
        .inst_hit   (inst_hit),
        .data_key   (data_key),
        .probe      (probe),
        .probe_key  (probe_key),
        .data_hit   (data_hit)
    );

    addr_translate inst_translate (
        .vaddr (inst_vaddr),
        .store (1'b0),  // Fetches never write
        .asid  (asid),
        .key   (inst_key),
        .hit   (inst_hit),
        .paddr (inst_paddr),
        .fault (inst_fault)
    );

    addr_translate data_translate (
        .vaddr (data_vaddr),
        .store (data_store),
        .asid  (asid),
        .key   (data_key),
        .hit   (data_hit),
        .paddr (data_paddr),
        .fault (data_fault)
    );
endmodule

`default_nettype wire

//--- hdl/addr_translate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_translate (
    input  logic [31:0]                vaddr,
    input  logic                       store,
    input  logic [mmu_pkg::ASID_W-1:0] asid,
    output mmu_pkg::tlb_key_t          key,
    input  mmu_pkg::tlb_hit_t          hit,
    output logic [31:0]                paddr,
    output mmu_pkg::tlb_fault_e        fault
);
    logic               unmapped;
    mmu_pkg::tlb_page_t page;

    assign unmapped = (vaddr[31:30] == 2'b10);  // kseg0 and kseg1
    assign key.vpn2 = vaddr[31 -: mmu_pkg::VPN2_W];
    assign key.asid = asid;
    assign page     = vaddr[12] ? hit.lo1 : hit.lo0;  // Odd page in lo1

    always_comb begin
        if (unmapped) begin
            paddr = {3'b000, vaddr[28:0]};
            fault = mmu_pkg::FAULT_NONE;
        end else begin
            paddr = {page.pfn, vaddr[11:0]};
            if (!hit.found) begin
                fault = mmu_pkg::FAULT_REFILL;
            end else if (!page.v) begin
                fault = mmu_pkg::FAULT_INVALID;
            end else if (store && !page.d) begin
                fault = mmu_pkg::FAULT_MODIFIED;
            end else begin
                fault = mmu_pkg::FAULT_NONE;
            end
        end
    end
endmodule

`default_nettype wire

//--- hdl/cp0_tlb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tlb_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  mmu_pkg::cp0_op_e              op,
    input  mmu_pkg::cp0_reg_e             sel,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata,
    output mmu_pkg::tlb_write_t           wr,
    output logic [mmu_pkg::TLB_IDX_W-1:0] read_index,
    input  mmu_pkg::tlb_entry_t           read_entry,
    output logic                          probe,
    output mmu_pkg::tlb_key_t             probe_key,
    input  mmu_pkg::tlb_hit_t             probe_hit,
    output logic [mmu_pkg::ASID_W-1:0]    asid
);
    logic                          index_p;  // Probe failed
    logic [mmu_pkg::TLB_IDX_W-1:0] index;
    logic [mmu_pkg::TLB_IDX_W-1:0] random;
    mmu_pkg::tlb_key_t             entry_hi;
    mmu_pkg::tlb_page_t            lo0;
    mmu_pkg::tlb_page_t            lo1;
    logic                          g0;
    logic                          g1;

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p  <= 1'b0;
            index    <= '0;
            random   <= '1;
            entry_hi <= '0;
            lo0      <= '0;
            lo1      <= '0;
            g0       <= 1'b0;
            g1       <= 1'b0;
        end else begin
            random <= random - 1'b1;  // Wraps from 0 to 15
            case (op)
                mmu_pkg::MTC0: begin
                    case (sel)
                        mmu_pkg::REG_INDEX: index <= wdata[mmu_pkg::TLB_IDX_W-1:0];
                        mmu_pkg::REG_ENTRYHI: begin
                            entry_hi.vpn2 <= wdata[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W];
                            entry_hi.asid <= wdata[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W];
                        end
                        mmu_pkg::REG_ENTRYLO0: begin
                            lo0 <= mmu_pkg::lo_unpack(wdata);
                            g0  <= wdata[mmu_pkg::LO_G_BIT];
                        end
                        mmu_pkg::REG_ENTRYLO1: begin
                            lo1 <= mmu_pkg::lo_unpack(wdata);
                            g1  <= wdata[mmu_pkg::LO_G_BIT];
                        end
                        default: begin
                        end  // Random is read only
                    endcase
                end
                mmu_pkg::TLBP: begin
                    index_p <= ~probe_hit.found;
                    index   <= probe_hit.index;
                end
                mmu_pkg::TLBR: begin
                    entry_hi.vpn2 <= read_entry.vpn2;
                    entry_hi.asid <= read_entry.asid;
                    lo0           <= read_entry.lo0;
                    lo1           <= read_entry.lo1;
                    g0            <= read_entry.g;
                    g1            <= read_entry.g;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (sel)
            mmu_pkg::REG_INDEX: begin
                rdata[mmu_pkg::IDX_P_BIT]           = index_p;
                rdata[mmu_pkg::TLB_IDX_W-1:0]       = index;
            end
            mmu_pkg::REG_RANDOM: rdata[mmu_pkg::TLB_IDX_W-1:0] = random;
            mmu_pkg::REG_ENTRYHI: begin
                rdata[mmu_pkg::HI_VPN2_LSB +: mmu_pkg::VPN2_W] = entry_hi.vpn2;
                rdata[mmu_pkg::HI_ASID_LSB +: mmu_pkg::ASID_W] = entry_hi.asid;
            end
            mmu_pkg::REG_ENTRYLO0: rdata = mmu_pkg::lo_pack(lo0, g0);
            mmu_pkg::REG_ENTRYLO1: rdata = mmu_pkg::lo_pack(lo1, g1);
            default: rdata = '0;
        endcase
    end

    // Entry image for TLBWI and TLBWR
    always_comb begin
        wr.en         = (op == mmu_pkg::TLBWI) || (op == mmu_pkg::TLBWR);
        wr.index      = (op == mmu_pkg::TLBWR) ? random : index;
        wr.entry.vpn2 = entry_hi.vpn2;
        wr.entry.asid = entry_hi.asid;
        wr.entry.g    = g0 & g1;
        wr.entry.lo0  = lo0;
        wr.entry.lo1  = lo1;
    end

    assign read_index = index;
    assign probe      = (op == mmu_pkg::TLBP);
    assign probe_key  = entry_hi;
    assign asid       = entry_hi.asid;
endmodule

`default_nettype wire

//--- hdl/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb (
    input  logic                          clk,
    input  logic                          reset,
    input  mmu_pkg::tlb_write_t           wr,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] read_index,
    output mmu_pkg::tlb_entry_t           read_entry,
    input  mmu_pkg::tlb_key_t             inst_key,
    output mmu_pkg::tlb_hit_t             inst_hit,
    input  mmu_pkg::tlb_key_t             data_key,
    input  logic                          probe,
    input  mmu_pkg::tlb_key_t             probe_key,
    output mmu_pkg::tlb_hit_t             data_hit
);
    mmu_pkg::tlb_entry_t           entries [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::tlb_key_t             search_key;
    logic                          inst_found;
    logic                          data_found;
    logic [mmu_pkg::TLB_IDX_W-1:0] inst_index;
    logic [mmu_pkg::TLB_IDX_W-1:0] data_index;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (wr.en) begin
            entries[wr.index] <= wr.entry;
        end
    end

    assign read_entry = entries[read_index];  // For TLBR

    // TLBP borrows the data-side search port
    assign search_key = probe ? probe_key : data_key;

    tlb_lookup inst_lookup (
        .key     (inst_key),
        .entries (entries),
        .found   (inst_found),
        .index   (inst_index)
    );

    tlb_lookup data_lookup (
        .key     (search_key),
        .entries (entries),
        .found   (data_found),
        .index   (data_index)
    );

    always_comb begin
        inst_hit.found = inst_found;
        inst_hit.index = inst_index;
        inst_hit.lo0   = entries[inst_index].lo0;
        inst_hit.lo1   = entries[inst_index].lo1;

        data_hit.found = data_found;
        data_hit.index = data_index;
        data_hit.lo0   = entries[data_index].lo0;
        data_hit.lo1   = entries[data_index].lo1;
    end
endmodule

`default_nettype wire

//--- hdl/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup (
    input  mmu_pkg::tlb_key_t             key,
    input  mmu_pkg::tlb_entry_t           entries [mmu_pkg::TLB_ENTRIES],
    output logic                          found,
    output logic [mmu_pkg::TLB_IDX_W-1:0] index
);
    logic [mmu_pkg::TLB_ENTRIES-1:0] hits;

    always_comb begin
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            hits[i] = (entries[i].vpn2 == key.vpn2) &&
                      ((entries[i].asid == key.asid) || entries[i].g);
        end
    end

    assign found = |hits;

    // Miss or multiple hit encodes as 0
    always_comb begin
        index = '0;
        if ($onehot(hits)) begin
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                if (hits[i]) begin
                    index = i[mmu_pkg::TLB_IDX_W-1:0];
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- hdl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int VPN2_W      = 19;
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;

    // EntryLo fields
    localparam int LO_PFN_LSB  = 6;
    localparam int LO_C_LSB    = 3;
    localparam int LO_D_BIT    = 2;
    localparam int LO_V_BIT    = 1;
    localparam int LO_G_BIT    = 0;
    // EntryHi and Index fields
    localparam int HI_VPN2_LSB = 13;
    localparam int HI_ASID_LSB = 0;
    localparam int IDX_P_BIT   = 31;

    typedef struct packed {
        logic [PFN_W-1:0] pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         lo0;
        tlb_page_t         lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
    } tlb_key_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        tlb_page_t            lo0;
        tlb_page_t            lo1;
    } tlb_hit_t;

    typedef struct packed {
        logic                 en;
        logic [TLB_IDX_W-1:0] index;
        tlb_entry_t           entry;
    } tlb_write_t;

    typedef enum logic [2:0] {NOP, MTC0, TLBP, TLBR, TLBWI, TLBWR} cp0_op_e;

    typedef enum logic [2:0] {
        REG_INDEX,
        REG_RANDOM,
        REG_ENTRYHI,
        REG_ENTRYLO0,
        REG_ENTRYLO1
    } cp0_reg_e;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_REFILL,
        FAULT_INVALID,
        FAULT_MODIFIED
    } tlb_fault_e;

    // EntryLo register image from a page and its g bit
    function automatic logic [31:0] lo_pack(tlb_page_t page, logic g);
        logic [31:0] r;
        r = '0;
        r[LO_PFN_LSB +: PFN_W] = page.pfn;
        r[LO_C_LSB +: 3]       = page.c;
        r[LO_D_BIT]            = page.d;
        r[LO_V_BIT]            = page.v;
        r[LO_G_BIT]            = g;
        return r;
    endfunction

    function automatic tlb_page_t lo_unpack(logic [31:0] r);
        tlb_page_t page;
        page.pfn = r[LO_PFN_LSB +: PFN_W];
        page.c   = r[LO_C_LSB +: 3];
        page.d   = r[LO_D_BIT];
        page.v   = r[LO_V_BIT];
        return page;
    endfunction
endpackage

`default_nettype wire
